/* rtl/id_pkg.sv */
package id_pkg;

	localparam int WORD_W     = 32;
	localparam int REG_ADDR_W = 5;

	localparam logic [REG_ADDR_W-1:0] LINK_REG = 5'd31;

	////////////////////////////////////////
	// Instruction encodings
	////////////////////////////////////////

	localparam logic [5:0] OPC_SPECIAL = 6'b000000;
	localparam logic [5:0] OPC_REGIMM  = 6'b000001;
	localparam logic [5:0] OPC_J       = 6'b000010;
	localparam logic [5:0] OPC_JAL     = 6'b000011;
	localparam logic [5:0] OPC_BEQ     = 6'b000100;
	localparam logic [5:0] OPC_BNE     = 6'b000101;
	localparam logic [5:0] OPC_BLEZ    = 6'b000110;
	localparam logic [5:0] OPC_BGTZ    = 6'b000111;
	localparam logic [5:0] OPC_ADDIU   = 6'b001001;
	localparam logic [5:0] OPC_SLTI    = 6'b001010;
	localparam logic [5:0] OPC_SLTIU   = 6'b001011;
	localparam logic [5:0] OPC_ANDI    = 6'b001100;
	localparam logic [5:0] OPC_ORI     = 6'b001101;
	localparam logic [5:0] OPC_XORI    = 6'b001110;
	localparam logic [5:0] OPC_LUI     = 6'b001111;

	// SPECIAL function field
	localparam logic [5:0] FN_SLL     = 6'b000000;
	localparam logic [5:0] FN_SRL     = 6'b000010;
	localparam logic [5:0] FN_SRA     = 6'b000011;
	localparam logic [5:0] FN_SLLV    = 6'b000100;
	localparam logic [5:0] FN_SRLV    = 6'b000110;
	localparam logic [5:0] FN_SRAV    = 6'b000111;
	localparam logic [5:0] FN_JR      = 6'b001000;
	localparam logic [5:0] FN_JALR    = 6'b001001;
	localparam logic [5:0] FN_SYSCALL = 6'b001100;
	localparam logic [5:0] FN_ADDU    = 6'b100001;
	localparam logic [5:0] FN_SUBU    = 6'b100011;
	localparam logic [5:0] FN_AND     = 6'b100100;
	localparam logic [5:0] FN_OR      = 6'b100101;
	localparam logic [5:0] FN_XOR     = 6'b100110;
	localparam logic [5:0] FN_NOR     = 6'b100111;
	localparam logic [5:0] FN_SLT     = 6'b101010;
	localparam logic [5:0] FN_SLTU    = 6'b101011;

	// REGIMM selectors in rt
	localparam logic [REG_ADDR_W-1:0] RT_BLTZ = 5'b00000;
	localparam logic [REG_ADDR_W-1:0] RT_BGEZ = 5'b00001;

	////////////////////////////////////////
	// Decoded codes
	////////////////////////////////////////

	typedef enum logic [2:0] {
		ALUSEL_LOGIC  = 3'b001,
		ALUSEL_SHIFT  = 3'b010,
		ALUSEL_ARITH  = 3'b100,
		ALUSEL_BRANCH = 3'b110,
		ALUSEL_TRAP   = 3'b111
	} alusel_e;

	typedef enum logic [7:0] {
		OP_SLL  = 8'h7c, OP_SRL  = 8'h02, OP_SRA  = 8'h03,
		OP_SLLV = 8'h04, OP_SRLV = 8'h06, OP_SRAV = 8'h07,
		OP_AND  = 8'h24, OP_OR   = 8'h25, OP_XOR  = 8'h26, OP_NOR = 8'h27,
		OP_ANDI = 8'h59, OP_ORI  = 8'h5a, OP_XORI = 8'h5b, OP_LUI = 8'h5c,
		OP_ADDU = 8'h21, OP_SUBU = 8'h23, OP_SLT  = 8'h2a, OP_SLTU = 8'h2b,
		OP_ADDIU = 8'h56, OP_SLTI = 8'h57, OP_SLTIU = 8'h58,
		OP_J    = 8'h4f, OP_JAL  = 8'h50, OP_JR   = 8'h08, OP_JALR = 8'h09,
		OP_BEQ  = 8'h51, OP_BNE  = 8'h52, OP_BLEZ = 8'h53, OP_BGTZ = 8'h54,
		OP_BLTZ = 8'h40, OP_BGEZ = 8'h41,
		OP_SYSCALL = 8'h0c
	} aluop_e;

	typedef enum logic [4:0] {
		EXC_NONE = 5'h00,
		EXC_SYS  = 5'h08,
		EXC_RI   = 5'h0a
	} exc_code_e;

	typedef enum logic [3:0] {
		BR_NONE, BR_J, BR_JAL, BR_JR, BR_JALR, BR_BEQ,
		BR_BNE, BR_BGTZ, BR_BLEZ, BR_BLTZ, BR_BGEZ
	} br_kind_e;

	////////////////////////////////////////
	// Records
	////////////////////////////////////////

	typedef struct packed {
		logic                  wreg;
		logic [REG_ADDR_W-1:0] wd;
		logic [WORD_W-1:0]     wdata;
	} wb_bypass_t;

	typedef struct packed {
		logic                  rd1_en;
		logic [REG_ADDR_W-1:0] rd1_addr;
		logic                  rd2_en;
		logic [REG_ADDR_W-1:0] rd2_addr;
	} rf_req_t;

	typedef struct packed {
		alusel_e               alusel;
		aluop_e                aluop;
		logic                  wreg;
		logic [REG_ADDR_W-1:0] wd;
		br_kind_e              br_kind;
		exc_code_e             exc_code;
	} ctrl_t;

	typedef struct packed {
		alusel_e               alusel;
		aluop_e                aluop;
		logic [WORD_W-1:0]     reg1;
		logic [WORD_W-1:0]     reg2;
		logic [REG_ADDR_W-1:0] wd;
		logic                  wreg;
		logic [WORD_W-1:0]     link_addr;
		logic                  in_delay;
		logic [WORD_W-1:0]     inst;
		exc_code_e             exc_code;
		logic [WORD_W-1:0]     exc_epc;
		logic [WORD_W-1:0]     exc_badvaddr;
	} issue_t;

	typedef struct packed {
		logic              flag;
		logic              next_delay;
		logic [WORD_W-1:0] addr;
	} branch_t;

endpackage

/* rtl/inst_decoder.sv */
module inst_decoder import id_pkg::*; (
	input  logic [WORD_W-1:0] inst_i,
	output ctrl_t             ctrl_o,
	output rf_req_t           rf_req_o,
	output logic [WORD_W-1:0] imm_o
);

	logic [5:0]            opcode;
	logic [5:0]            funct;
	logic [REG_ADDR_W-1:0] rs;
	logic [REG_ADDR_W-1:0] rt;
	logic [REG_ADDR_W-1:0] rd;
	logic [REG_ADDR_W-1:0] sa;
	logic [WORD_W-1:0]     imm_zx;
	logic [WORD_W-1:0]     imm_sx;
	logic [WORD_W-1:0]     imm_sa;
	aluop_e                op_dec;
	logic                  legal;

	assign opcode = inst_i[31:26];
	assign rs     = inst_i[25:21];
	assign rt     = inst_i[20:16];
	assign rd     = inst_i[15:11];
	assign sa     = inst_i[10:6];
	assign funct  = inst_i[5:0];

	assign imm_zx = {{(WORD_W-16){1'b0}}, inst_i[15:0]};
	assign imm_sx = {{(WORD_W-16){inst_i[15]}}, inst_i[15:0]};
	assign imm_sa = {{(WORD_W-REG_ADDR_W){1'b0}}, sa};

	////////////////////////////////////////
	// Instruction identification
	////////////////////////////////////////

	always_comb begin
		op_dec = OP_SLL;
		legal  = 1'b1;
		case (opcode)
			OPC_SPECIAL: begin
				case (funct)
					FN_AND:     op_dec = OP_AND;
					FN_OR:      op_dec = OP_OR;
					FN_XOR:     op_dec = OP_XOR;
					FN_NOR:     op_dec = OP_NOR;
					FN_SLL:     op_dec = OP_SLL;
					FN_SRL:     op_dec = OP_SRL;
					FN_SRA:     op_dec = OP_SRA;
					FN_SLLV:    op_dec = OP_SLLV;
					FN_SRLV:    op_dec = OP_SRLV;
					FN_SRAV:    op_dec = OP_SRAV;
					FN_ADDU:    op_dec = OP_ADDU;
					FN_SUBU:    op_dec = OP_SUBU;
					FN_SLT:     op_dec = OP_SLT;
					FN_SLTU:    op_dec = OP_SLTU;
					FN_JR:      op_dec = OP_JR;
					FN_JALR:    op_dec = OP_JALR;
					FN_SYSCALL: op_dec = OP_SYSCALL;
					default:    legal = 1'b0;
				endcase
			end
			OPC_REGIMM: begin
				case (rt)
					RT_BLTZ: op_dec = OP_BLTZ;
					RT_BGEZ: op_dec = OP_BGEZ;
					default: legal = 1'b0;
				endcase
			end
			OPC_J:     op_dec = OP_J;
			OPC_JAL:   op_dec = OP_JAL;
			OPC_BEQ:   op_dec = OP_BEQ;
			OPC_BNE:   op_dec = OP_BNE;
			OPC_BLEZ:  op_dec = OP_BLEZ;
			OPC_BGTZ:  op_dec = OP_BGTZ;
			OPC_ADDIU: op_dec = OP_ADDIU;
			OPC_SLTI:  op_dec = OP_SLTI;
			OPC_SLTIU: op_dec = OP_SLTIU;
			OPC_ANDI:  op_dec = OP_ANDI;
			OPC_ORI:   op_dec = OP_ORI;
			OPC_XORI:  op_dec = OP_XORI;
			OPC_LUI:   op_dec = OP_LUI;
			default:   legal = 1'b0;
		endcase
	end

	////////////////////////////////////////
	// Control record and register reads
	////////////////////////////////////////

	always_comb begin
		ctrl_o          = '0;
		ctrl_o.alusel   = ALUSEL_SHIFT;
		ctrl_o.aluop    = op_dec;
		ctrl_o.br_kind  = BR_NONE;
		ctrl_o.exc_code = EXC_NONE;
		rf_req_o        = '0;
		imm_o           = '0;
		if (!legal) begin
			// Reserved instruction turns into a NOP
			ctrl_o.exc_code = EXC_RI;
		end else begin
			case (op_dec)
				OP_AND, OP_OR, OP_XOR, OP_NOR, OP_ANDI, OP_ORI, OP_XORI, OP_LUI:
					ctrl_o.alusel = ALUSEL_LOGIC;
				OP_SLL, OP_SRL, OP_SRA, OP_SLLV, OP_SRLV, OP_SRAV:
					ctrl_o.alusel = ALUSEL_SHIFT;
				OP_ADDU, OP_SUBU, OP_SLT, OP_SLTU, OP_ADDIU, OP_SLTI, OP_SLTIU:
					ctrl_o.alusel = ALUSEL_ARITH;
				OP_SYSCALL:
					ctrl_o.alusel = ALUSEL_TRAP;
				default:
					ctrl_o.alusel = ALUSEL_BRANCH;
			endcase

			case (op_dec)
				OP_J:    ctrl_o.br_kind = BR_J;
				OP_JAL:  ctrl_o.br_kind = BR_JAL;
				OP_JR:   ctrl_o.br_kind = BR_JR;
				OP_JALR: ctrl_o.br_kind = BR_JALR;
				OP_BEQ:  ctrl_o.br_kind = BR_BEQ;
				OP_BNE:  ctrl_o.br_kind = BR_BNE;
				OP_BGTZ: ctrl_o.br_kind = BR_BGTZ;
				OP_BLEZ: ctrl_o.br_kind = BR_BLEZ;
				OP_BLTZ: ctrl_o.br_kind = BR_BLTZ;
				OP_BGEZ: ctrl_o.br_kind = BR_BGEZ;
				default: ctrl_o.br_kind = BR_NONE;
			endcase

			case (op_dec)
				// rd <- rs op rt
				OP_AND, OP_OR, OP_XOR, OP_NOR, OP_ADDU, OP_SUBU, OP_SLT, OP_SLTU: begin
					ctrl_o.wreg       = 1'b1;
					ctrl_o.wd         = rd;
					rf_req_o.rd1_en   = 1'b1;
					rf_req_o.rd1_addr = rs;
					rf_req_o.rd2_en   = 1'b1;
					rf_req_o.rd2_addr = rt;
				end
				// Shift amount goes out as operand 2
				OP_SLL, OP_SRL, OP_SRA: begin
					ctrl_o.wreg       = 1'b1;
					ctrl_o.wd         = rd;
					rf_req_o.rd1_en   = 1'b1;
					rf_req_o.rd1_addr = rt;
					imm_o             = imm_sa;
				end
				OP_SLLV, OP_SRLV, OP_SRAV: begin
					ctrl_o.wreg       = 1'b1;
					ctrl_o.wd         = rd;
					rf_req_o.rd1_en   = 1'b1;
					rf_req_o.rd1_addr = rt;
					rf_req_o.rd2_en   = 1'b1;
					rf_req_o.rd2_addr = rs;
				end
				OP_ANDI, OP_ORI, OP_XORI, OP_ADDIU, OP_SLTI, OP_SLTIU: begin
					ctrl_o.wreg       = 1'b1;
					ctrl_o.wd         = rt;
					rf_req_o.rd1_en   = 1'b1;
					rf_req_o.rd1_addr = rs;
					imm_o = (op_dec inside {OP_ANDI, OP_ORI, OP_XORI}) ? imm_zx : imm_sx;
				end
				OP_LUI: begin
					ctrl_o.wreg = 1'b1;
					ctrl_o.wd   = rt;
					imm_o       = imm_zx;
				end
				OP_JAL: begin
					ctrl_o.wreg = 1'b1;
					ctrl_o.wd   = LINK_REG;
				end
				OP_JALR: begin
					ctrl_o.wreg       = 1'b1;
					ctrl_o.wd         = rd;
					rf_req_o.rd1_en   = 1'b1;
					rf_req_o.rd1_addr = rs;
				end
				OP_JR, OP_BGTZ, OP_BLEZ, OP_BLTZ, OP_BGEZ: begin
					rf_req_o.rd1_en   = 1'b1;
					rf_req_o.rd1_addr = rs;
				end
				OP_BEQ, OP_BNE: begin
					rf_req_o.rd1_en   = 1'b1;
					rf_req_o.rd1_addr = rs;
					rf_req_o.rd2_en   = 1'b1;
					rf_req_o.rd2_addr = rt;
				end
				OP_SYSCALL:
					ctrl_o.exc_code = EXC_SYS;
				default:
					ctrl_o.wreg = 1'b0;
			endcase
		end
	end

endmodule

/* rtl/operand_forward.sv */
module operand_forward import id_pkg::*; (
	input  logic                  rd_en_i,
	input  logic [REG_ADDR_W-1:0] rd_addr_i,
	input  logic [WORD_W-1:0]     rf_data_i,
	input  logic [WORD_W-1:0]     imm_i,
	input  wb_bypass_t            ex_byp_i,
	input  wb_bypass_t            mem_byp_i,
	output logic [WORD_W-1:0]     operand_o
);

	logic ex_hit;
	logic mem_hit;

	assign ex_hit  = ex_byp_i.wreg && (ex_byp_i.wd == rd_addr_i);
	assign mem_hit = mem_byp_i.wreg && (mem_byp_i.wd == rd_addr_i);

	// Youngest result wins
	always_comb begin
		if (!rd_en_i)
			operand_o = imm_i;
		else if (ex_hit)
			operand_o = ex_byp_i.wdata;
		else if (mem_hit)
			operand_o = mem_byp_i.wdata;
		else
			operand_o = rf_data_i;
	end

endmodule

/* rtl/branch_unit.sv */
module branch_unit import id_pkg::*; (
	input  br_kind_e          kind_i,
	input  logic [WORD_W-1:0] pc_i,
	input  logic [WORD_W-1:0] inst_i,
	input  logic [WORD_W-1:0] reg1_i,
	input  logic [WORD_W-1:0] reg2_i,
	output branch_t           branch_o,
	output logic [WORD_W-1:0] link_addr_o
);

	logic [WORD_W-1:0] pc_plus4;
	logic [WORD_W-1:0] pc_plus8;
	logic [WORD_W-1:0] jump_target;
	logic [WORD_W-1:0] rel_target;
	logic [WORD_W-1:0] target;
	logic              taken;

	assign pc_plus4 = pc_i + WORD_W'(4);
	assign pc_plus8 = pc_i + WORD_W'(8);

	// Region jump keeps the top nibble of the delay slot address
	assign jump_target = {pc_plus4[WORD_W-1:WORD_W-4], inst_i[25:0], 2'b00};
	assign rel_target  = pc_plus4 + {{(WORD_W-18){inst_i[15]}}, inst_i[15:0], 2'b00};

	always_comb begin
		target = rel_target;
		case (kind_i)
			BR_J, BR_JAL: begin
				taken  = 1'b1;
				target = jump_target;
			end
			BR_JR, BR_JALR: begin
				taken  = 1'b1;
				target = reg1_i;
			end
			BR_BEQ:  taken = (reg1_i == reg2_i);
			BR_BNE:  taken = (reg1_i != reg2_i);
			BR_BGTZ: taken = !reg1_i[WORD_W-1] && (reg1_i != '0);
			BR_BLEZ: taken = reg1_i[WORD_W-1] || (reg1_i == '0);
			BR_BLTZ: taken = reg1_i[WORD_W-1];
			BR_BGEZ: taken = !reg1_i[WORD_W-1];
			default: taken = 1'b0;
		endcase
	end

	always_comb begin
		branch_o.flag       = taken;
		branch_o.next_delay = (kind_i != BR_NONE);
		branch_o.addr       = taken ? target : '0;
		if (kind_i == BR_JAL || kind_i == BR_JALR)
			link_addr_o = pc_plus8;
		else
			link_addr_o = '0;
	end

endmodule

/* rtl/issue_reg.sv */
module issue_reg import id_pkg::*; (
	input  logic              clk,
	input  logic              rst_n_i,
	input  logic              valid_i,
	input  ctrl_t             ctrl_i,
	input  logic [WORD_W-1:0] pc_i,
	input  logic [WORD_W-1:0] inst_i,
	input  logic              in_delay_i,
	input  logic [WORD_W-1:0] reg1_i,
	input  logic [WORD_W-1:0] reg2_i,
	input  logic [WORD_W-1:0] link_addr_i,
	input  branch_t           branch_i,
	output logic              issue_valid_o,
	output issue_t            issue_o,
	output branch_t           branch_o
);

	issue_t issue_d;

	always_comb begin
		issue_d.alusel    = ctrl_i.alusel;
		issue_d.aluop     = ctrl_i.aluop;
		issue_d.reg1      = reg1_i;
		issue_d.reg2      = reg2_i;
		issue_d.wd        = ctrl_i.wd;
		issue_d.wreg      = ctrl_i.wreg;
		issue_d.link_addr = link_addr_i;
		issue_d.in_delay  = in_delay_i;
		issue_d.inst      = inst_i;
		issue_d.exc_code  = ctrl_i.exc_code;
		// Delay slot faults restart at the branch
		issue_d.exc_epc   = in_delay_i ? (pc_i - WORD_W'(4)) : pc_i;
		issue_d.exc_badvaddr = (ctrl_i.exc_code == EXC_RI) ? inst_i : '0;
	end

	////////////////////////////////////////
	// Stage register
	////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			issue_valid_o <= 1'b0;
			issue_o       <= '0;
			branch_o      <= '0;
		end else begin
			issue_valid_o <= valid_i;
			// Hold the last bundle between strobes
			if (valid_i) begin
				issue_o  <= issue_d;
				branch_o <= branch_i;
			end
		end
	end

endmodule

/* rtl/id_stage.sv */
module id_stage import id_pkg::*; (
	input  logic              clk,
	input  logic              rst_n_i,
	input  logic              inst_valid_i,
	input  logic [WORD_W-1:0] pc_i,
	input  logic [WORD_W-1:0] inst_i,
	input  logic              in_delay_i,
	input  logic [WORD_W-1:0] rf_data1_i,
	input  logic [WORD_W-1:0] rf_data2_i,
	input  wb_bypass_t        ex_byp_i,
	input  wb_bypass_t        mem_byp_i,
	output rf_req_t           rf_req_o,
	output logic              issue_valid_o,
	output issue_t            issue_o,
	output branch_t           branch_o
);

	ctrl_t             dec_ctrl;
	logic [WORD_W-1:0] dec_imm;
	logic [WORD_W-1:0] reg1;
	logic [WORD_W-1:0] reg2;
	logic [WORD_W-1:0] link_addr;
	branch_t           br_res;

	inst_decoder u_decoder (
		.inst_i   (inst_i),
		.ctrl_o   (dec_ctrl),
		.rf_req_o (rf_req_o),
		.imm_o    (dec_imm)
	);

	////////////////////////////////////////
	// Operand bypass
	////////////////////////////////////////

	operand_forward u_fwd1 (
		.rd_en_i   (rf_req_o.rd1_en),
		.rd_addr_i (rf_req_o.rd1_addr),
		.rf_data_i (rf_data1_i),
		.imm_i     (dec_imm),
		.ex_byp_i  (ex_byp_i),
		.mem_byp_i (mem_byp_i),
		.operand_o (reg1)
	);

	operand_forward u_fwd2 (
		.rd_en_i   (rf_req_o.rd2_en),
		.rd_addr_i (rf_req_o.rd2_addr),
		.rf_data_i (rf_data2_i),
		.imm_i     (dec_imm),
		.ex_byp_i  (ex_byp_i),
		.mem_byp_i (mem_byp_i),
		.operand_o (reg2)
	);

	// Branches resolve on forwarded operands
	branch_unit u_branch (
		.kind_i      (dec_ctrl.br_kind),
		.pc_i        (pc_i),
		.inst_i      (inst_i),
		.reg1_i      (reg1),
		.reg2_i      (reg2),
		.branch_o    (br_res),
		.link_addr_o (link_addr)
	);

	issue_reg u_issue (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.valid_i       (inst_valid_i),
		.ctrl_i        (dec_ctrl),
		.pc_i          (pc_i),
		.inst_i        (inst_i),
		.in_delay_i    (in_delay_i),
		.reg1_i        (reg1),
		.reg2_i        (reg2),
		.link_addr_i   (link_addr),
		.branch_i      (br_res),
		.issue_valid_o (issue_valid_o),
		.issue_o       (issue_o),
		.branch_o      (branch_o)
	);

endmodule

/* testbench/id_properties.sv */
module id_properties import id_pkg::*; (
	input logic    clk,
	input logic    rst_n_i,
	input logic    inst_valid_i,
	input logic    issue_valid_o,
	input issue_t  issue_o,
	input branch_t branch_o
);

	timeunit 1ns;
	timeprecision 1ps;

	// A taken branch always opens a delay slot
	flag_has_delay: assert property (@(posedge clk) disable iff (!rst_n_i)
		branch_o.flag |-> branch_o.next_delay)
		else $error("branch flag set without next_delay");

	valid_after_strobe: assert property (@(posedge clk) disable iff (!rst_n_i)
		inst_valid_i |=> issue_valid_o)
		else $error("issue_valid_o missing one cycle after a strobe");

	valid_needs_strobe: assert property (@(posedge clk) disable iff (!rst_n_i)
		issue_valid_o |-> $past(inst_valid_i))
		else $error("issue_valid_o high without a strobe one cycle before");

	ri_no_write: assert property (@(posedge clk) disable iff (!rst_n_i)
		(issue_o.exc_code == EXC_RI) |-> !issue_o.wreg)
		else $error("reserved instruction issued with a register write");

endmodule

bind id_stage id_properties u_props (.*);

/* testbench/tb_id_stage.sv */
module tb_id_stage import id_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int RESET_CYCLES = 2;
	localparam int N_CYCLES     = 2000;
	localparam int CYCLE_LIMIT  = RESET_CYCLES + N_CYCLES + 1 + 20;

	// Kept encodings as {opcode, funct or rt, aluop}
	localparam logic [19:0] KEPT [32] = '{
		{OPC_SPECIAL, FN_AND, OP_AND}, {OPC_SPECIAL, FN_OR, OP_OR},
		{OPC_SPECIAL, FN_XOR, OP_XOR}, {OPC_SPECIAL, FN_NOR, OP_NOR},
		{OPC_SPECIAL, FN_SLL, OP_SLL}, {OPC_SPECIAL, FN_SRL, OP_SRL},
		{OPC_SPECIAL, FN_SRA, OP_SRA}, {OPC_SPECIAL, FN_SLLV, OP_SLLV},
		{OPC_SPECIAL, FN_SRLV, OP_SRLV}, {OPC_SPECIAL, FN_SRAV, OP_SRAV},
		{OPC_SPECIAL, FN_ADDU, OP_ADDU}, {OPC_SPECIAL, FN_SUBU, OP_SUBU},
		{OPC_SPECIAL, FN_SLT, OP_SLT}, {OPC_SPECIAL, FN_SLTU, OP_SLTU},
		{OPC_SPECIAL, FN_JR, OP_JR}, {OPC_SPECIAL, FN_JALR, OP_JALR},
		{OPC_SPECIAL, FN_SYSCALL, OP_SYSCALL},
		{OPC_REGIMM, 1'b0, RT_BLTZ, OP_BLTZ}, {OPC_REGIMM, 1'b0, RT_BGEZ, OP_BGEZ},
		{OPC_J, 6'd0, OP_J}, {OPC_JAL, 6'd0, OP_JAL}, {OPC_BEQ, 6'd0, OP_BEQ},
		{OPC_BNE, 6'd0, OP_BNE}, {OPC_BLEZ, 6'd0, OP_BLEZ}, {OPC_BGTZ, 6'd0, OP_BGTZ},
		{OPC_ADDIU, 6'd0, OP_ADDIU}, {OPC_SLTI, 6'd0, OP_SLTI},
		{OPC_SLTIU, 6'd0, OP_SLTIU}, {OPC_ANDI, 6'd0, OP_ANDI},
		{OPC_ORI, 6'd0, OP_ORI}, {OPC_XORI, 6'd0, OP_XORI}, {OPC_LUI, 6'd0, OP_LUI}
	};

	logic        clk = 1'b0;
	logic        rst_n_i;
	logic        inst_valid_i;
	logic [31:0] pc_i;
	logic [31:0] inst_i;
	logic        in_delay_i;
	logic [31:0] rf_data1_i;
	logic [31:0] rf_data2_i;
	wb_bypass_t  ex_byp_i;
	wb_bypass_t  mem_byp_i;
	rf_req_t     rf_req_o;
	logic        issue_valid_o;
	issue_t      issue_o;
	branch_t     branch_o;

	logic [31:0] lfsr = 32'h9fe9;
	logic [31:0] rf [32];
	issue_t      exp_issue_q[$];
	branch_t     exp_branch_q[$];
	rf_req_t     exp_req_q[$];
	issue_t      last_issue;
	branch_t     last_branch;
	int          checks = 0;
	int          errors = 0;
	int          cycle_count = 0;

	id_stage dut0 (.*);

	always #50 clk = ~clk;

	// Register file answers the read request
	assign rf_data1_i = rf[rf_req_o.rd1_addr];
	assign rf_data2_i = rf[rf_req_o.rd2_addr];

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > CYCLE_LIMIT) begin
			$display("Run stopped after %0d cycles without reaching the end", CYCLE_LIMIT);
			$display("Regression failed");
			$finish;
		end
	end

	////////////////////////////////////////
	// Random source and stimulus
	////////////////////////////////////////

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return v;
	endfunction

	function automatic logic [31:0] pick_instruction();
		logic [31:0] r;
		logic [19:0] k;
		logic [2:0]  mode;
		r    = rand_bits(32);
		mode = 3'(rand_bits(3));
		k    = KEPT[5'(rand_bits(5))];
		if (mode == 3'd0)
			return r;
		if (mode == 3'd1)
			return {OPC_SPECIAL, r[25:0]};
		case (k[19:14])
			OPC_SPECIAL: return {k[19:14], r[25:6], k[13:8]};
			OPC_REGIMM:  return {k[19:14], r[25:21], k[12:8], r[15:0]};
			default:     return {k[19:14], r[25:0]};
		endcase
	endfunction

	////////////////////////////////////////
	// Reference model
	////////////////////////////////////////

	function automatic logic [31:0] forwarded_value(input logic [4:0] a);
		if (ex_byp_i.wreg && ex_byp_i.wd == a)
			return ex_byp_i.wdata;
		if (mem_byp_i.wreg && mem_byp_i.wd == a)
			return mem_byp_i.wdata;
		return rf[a];
	endfunction

	task automatic predict(input logic [31:0] inst, input logic [31:0] pc, input logic dly,
			output issue_t e, output branch_t b, output rf_req_t q);
		logic [5:0]  opc;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [31:0] pc4;
		logic [31:0] tgt;
		logic        legal;
		logic        taken;
		aluop_e      op;
		opc   = inst[31:26];
		rs    = inst[25:21];
		rt    = inst[20:16];
		pc4   = pc + 32'd4;
		e     = '0;
		b     = '0;
		q     = '0;
		legal = 1'b0;
		op    = OP_SLL;
		e.inst     = inst;
		e.in_delay = dly;
		e.exc_epc  = dly ? pc - 32'd4 : pc;
		e.alusel   = ALUSEL_SHIFT;
		e.aluop    = OP_SLL;
		e.exc_code = EXC_NONE;
		for (int i = 0; i < 32; i++) begin
			if (KEPT[i][19:14] != opc)
				continue;
			if ((opc == OPC_SPECIAL && KEPT[i][13:8] != inst[5:0]) ||
					(opc == OPC_REGIMM && KEPT[i][12:8] != rt))
				continue;
			legal = 1'b1;
			op    = aluop_e'(KEPT[i][7:0]);
		end
		if (!legal) begin
			e.exc_code     = EXC_RI;
			e.exc_badvaddr = inst;
			return;
		end
		e.aluop  = op;
		e.alusel = ALUSEL_ARITH;
		e.wreg   = 1'b1;
		e.wd     = inst[15:11];
		e.reg1   = forwarded_value(rs);
		e.reg2   = forwarded_value(rt);
		q.rd1_en   = 1'b1;
		q.rd1_addr = rs;
		q.rd2_en   = 1'b1;
		q.rd2_addr = rt;
		case (op)
			OP_AND, OP_OR, OP_XOR, OP_NOR:
				e.alusel = ALUSEL_LOGIC;
			OP_ADDU, OP_SUBU, OP_SLT, OP_SLTU:
				e.alusel = ALUSEL_ARITH;
			OP_SLL, OP_SRL, OP_SRA, OP_SLLV, OP_SRLV, OP_SRAV: begin
				e.alusel = ALUSEL_SHIFT;
				e.reg1   = forwarded_value(rt);
				e.reg2   = (op inside {OP_SLL, OP_SRL, OP_SRA}) ?
					{27'd0, inst[10:6]} : forwarded_value(rs);
				q.rd1_addr = rt;
				q.rd2_addr = rs;
				if (op inside {OP_SLL, OP_SRL, OP_SRA})
					q.rd2_en = 1'b0;
			end
			OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
				e.alusel = ALUSEL_LOGIC;
				e.wd     = rt;
				e.reg2   = {16'd0, inst[15:0]};
				q.rd2_en = 1'b0;
				if (op == OP_LUI) begin
					e.reg1   = {16'd0, inst[15:0]};
					q.rd1_en = 1'b0;
				end
			end
			OP_ADDIU, OP_SLTI, OP_SLTIU: begin
				e.wd     = rt;
				e.reg2   = {{16{inst[15]}}, inst[15:0]};
				q.rd2_en = 1'b0;
			end
			OP_SYSCALL: begin
				e.alusel   = ALUSEL_TRAP;
				e.exc_code = EXC_SYS;
				e.wreg     = 1'b0;
				e.wd       = '0;
				e.reg1     = '0;
				e.reg2     = '0;
				q          = '0;
			end
			default: begin
				// Jumps and branches
				e.alusel = ALUSEL_BRANCH;
				e.wreg   = 1'b0;
				e.wd     = '0;
				if (!(op inside {OP_BEQ, OP_BNE})) begin
					e.reg2   = '0;
					q.rd2_en = 1'b0;
				end
				tgt = pc4 + {{14{inst[15]}}, inst[15:0], 2'b00};
				case (op)
					OP_J, OP_JAL: begin
						e.reg1   = '0;
						q.rd1_en = 1'b0;
						taken    = 1'b1;
						tgt      = {pc4[31:28], inst[25:0], 2'b00};
					end
					OP_JR, OP_JALR: begin
						taken = 1'b1;
						tgt   = e.reg1;
					end
					OP_BEQ:  taken = (e.reg1 == e.reg2);
					OP_BNE:  taken = (e.reg1 != e.reg2);
					OP_BGTZ: taken = ($signed(e.reg1) > 0);
					OP_BLEZ: taken = ($signed(e.reg1) <= 0);
					OP_BLTZ: taken = e.reg1[31];
					default: taken = !e.reg1[31];
				endcase
				if (op == OP_JAL || op == OP_JALR) begin
					e.wreg      = 1'b1;
					e.wd        = (op == OP_JAL) ? LINK_REG : inst[15:11];
					e.link_addr = pc + 32'd8;
				end
				b.flag       = taken;
				b.next_delay = 1'b1;
				b.addr       = taken ? tgt : '0;
			end
		endcase
	endtask

	////////////////////////////////////////
	// Checking
	////////////////////////////////////////

	task automatic compare_field(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_outputs();
		rf_req_t req;
		if (exp_issue_q.size() != 0) begin
			last_issue  = exp_issue_q.pop_front();
			last_branch = exp_branch_q.pop_front();
			req         = exp_req_q.pop_front();
			compare_field("issue_valid_o", 32'(issue_valid_o), 32'd1);
			// Instruction is still held, so the read request is settled
			compare_field("rd1_en", 32'(rf_req_o.rd1_en), 32'(req.rd1_en));
			if (req.rd1_en)
				compare_field("rd1_addr", 32'(rf_req_o.rd1_addr), 32'(req.rd1_addr));
			compare_field("rd2_en", 32'(rf_req_o.rd2_en), 32'(req.rd2_en));
			if (req.rd2_en)
				compare_field("rd2_addr", 32'(rf_req_o.rd2_addr), 32'(req.rd2_addr));
		end else begin
			compare_field("issue_valid_o", 32'(issue_valid_o), 32'd0);
		end
		compare_field("alusel", 32'(issue_o.alusel), 32'(last_issue.alusel));
		compare_field("aluop", 32'(issue_o.aluop), 32'(last_issue.aluop));
		compare_field("reg1", issue_o.reg1, last_issue.reg1);
		compare_field("reg2", issue_o.reg2, last_issue.reg2);
		compare_field("wd", 32'(issue_o.wd), 32'(last_issue.wd));
		compare_field("wreg", 32'(issue_o.wreg), 32'(last_issue.wreg));
		compare_field("link_addr", issue_o.link_addr, last_issue.link_addr);
		compare_field("in_delay", 32'(issue_o.in_delay), 32'(last_issue.in_delay));
		compare_field("inst", issue_o.inst, last_issue.inst);
		compare_field("exc_code", 32'(issue_o.exc_code), 32'(last_issue.exc_code));
		compare_field("exc_epc", issue_o.exc_epc, last_issue.exc_epc);
		compare_field("exc_badvaddr", issue_o.exc_badvaddr, last_issue.exc_badvaddr);
		compare_field("branch flag", 32'(branch_o.flag), 32'(last_branch.flag));
		compare_field("branch next_delay", 32'(branch_o.next_delay),
			32'(last_branch.next_delay));
		compare_field("branch addr", branch_o.addr, last_branch.addr);
	endtask

	task automatic drive_inputs();
		issue_t  e;
		branch_t b;
		rf_req_t q;
		inst_valid_i    = (rand_bits(2) != 0);
		pc_i            = {30'(rand_bits(30)), 2'b00};
		in_delay_i      = 1'(rand_bits(1));
		inst_i          = pick_instruction();
		ex_byp_i.wreg   = 1'(rand_bits(1));
		ex_byp_i.wd     = 5'(rand_bits(5));
		ex_byp_i.wdata  = rand_bits(32);
		mem_byp_i.wreg  = 1'(rand_bits(1));
		mem_byp_i.wd    = 5'(rand_bits(5));
		mem_byp_i.wdata = rand_bits(32);
		// Aim the bypasses at the source registers now and then
		if (rand_bits(2) == 0)
			ex_byp_i.wd = rand_bits(1) != 0 ? inst_i[25:21] : inst_i[20:16];
		if (rand_bits(2) == 0)
			mem_byp_i.wd = rand_bits(1) != 0 ? inst_i[25:21] : inst_i[20:16];
		if (inst_valid_i) begin
			predict(inst_i, pc_i, in_delay_i, e, b, q);
			exp_issue_q.push_back(e);
			exp_branch_q.push_back(b);
			exp_req_q.push_back(q);
		end
	endtask

	initial begin
		rst_n_i      = 1'b0;
		inst_valid_i = 1'b0;
		pc_i         = '0;
		inst_i       = '0;
		in_delay_i   = 1'b0;
		ex_byp_i     = '0;
		mem_byp_i    = '0;
		last_issue   = '0;
		last_branch  = '0;
		for (int i = 0; i < 32; i++)
			rf[i] = rand_bits(32);
		repeat (RESET_CYCLES) @(posedge clk);
		#5;
		rst_n_i = 1'b1;
		for (int n = 0; n < N_CYCLES; n++) begin
			@(posedge clk);
			#5;
			check_outputs();
			drive_inputs();
		end
		@(posedge clk);
		#5;
		check_outputs();
		$display("Checks: %0d, mismatches: %0d", checks, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

/* flist.f */
rtl/id_pkg.sv
rtl/inst_decoder.sv
rtl/operand_forward.sv
rtl/branch_unit.sv
rtl/issue_reg.sv
rtl/id_stage.sv
testbench/id_properties.sv
testbench/tb_id_stage.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_id_stage
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
